//--- logic/icache_pkg.sv
// shared types and constants for the instruction-cache lookup block
// every RTL file imports this package inside its module body
// the fetch address union is the one place an address word is split

`default_nettype none

package icache_pkg;

    // raw widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] mem_block_t;

    // cache geometry, direct mapped
    localparam int ICACHE_LINE_BITS = 5;
    localparam int ICACHE_LINES     = 32;
    localparam int ICACHE_TAG_BITS  = 8;

    // tag-entry fields
    typedef logic [ICACHE_TAG_BITS-1:0]  icache_tag_t;
    typedef logic [ICACHE_LINE_BITS-1:0] icache_index_t;

    // line address = addr[15:3] = {tag, index}
    typedef logic [ICACHE_TAG_BITS+ICACHE_LINE_BITS-1:0] line_addr_t;

    ////////////////////////////////////////////////////////////////////
    // fetch address, seen raw or split into cache fields
    ////////////////////////////////////////////////////////////////////
    typedef union packed {
        addr_t raw;
        struct packed {
            logic [15:0]   unused;
            icache_tag_t   tag;
            icache_index_t index;
            logic [2:0]    offset;
        } fields;
    } fetch_addr_u;

    // branch task from the branch logic
    // only a squash touches the cache state
    typedef enum logic [1:0] {
        BR_NONE    = 2'd0,
        BR_PREDICT = 2'd1,
        BR_SQUASH  = 2'd2
    } br_task_t;

endpackage

`default_nettype wire

//--- logic/icache_tag_store.sv
// tag, valid and allocation state of every cache line
// fills set tag and valid, allocates mark a line as requested,
// a squash drops every allocation flag and blocks that cycle's updates

`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
    input  logic                                                 clock,
    input  logic                                                 reset,

    // fill
    input  logic                                                 write_en,
    input  icache_pkg::addr_t                                    write_addr,

    // allocate
    input  logic                                                 alloc_en,
    input  icache_pkg::addr_t                                    alloc_addr,

    // from branch logic
    input  icache_pkg::br_task_t                                 br_task,

    // flattened state, read by every lane
    output icache_pkg::icache_tag_t [icache_pkg::ICACHE_LINES-1:0] tag_array,
    output logic [icache_pkg::ICACHE_LINES-1:0]                  valid_array,
    output logic [icache_pkg::ICACHE_LINES-1:0]                  alloc_array
);
    import icache_pkg::*;

    fetch_addr_u   write_dec;
    fetch_addr_u   alloc_dec;
    icache_index_t write_index;
    icache_index_t alloc_index;
    logic          squash;

    // address decode
    assign write_dec.raw = write_addr;
    assign alloc_dec.raw = alloc_addr;
    assign write_index   = write_dec.fields.index;
    assign alloc_index   = alloc_dec.fields.index;

    assign squash = (br_task == BR_SQUASH);

    //////////////////////////////////////////////////////////////////////
    // valid and allocation flags
    //////////////////////////////////////////////////////////////////////
    // priority: squash, then write, then allocate
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_array <= '0;
            alloc_array <= '0;
        end else if (squash) begin
            // drop all outstanding requests, ignore write and alloc
            alloc_array <= '0;
        end else begin
            if (write_en) begin
                valid_array[write_index] <= 1'b1;
                alloc_array[write_index] <= 1'b0;
            end
            // later assignment wins, so alloc after write leaves flag set
            if (alloc_en) begin
                alloc_array[alloc_index] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tags
    //////////////////////////////////////////////////////////////////////
    // only meaningful where valid is set
    always_ff @(posedge clock) begin
        if (write_en && !squash) begin
            tag_array[write_index] <= write_dec.fields.tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_data_store.sv
// block storage of the instruction cache
// one write port from the fill path and one combinational read port
// per lane of the lookup window

`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
    parameter int PREFETCH_DISTANCE = 4,
    parameter int DEPTH             = icache_pkg::ICACHE_LINES
) (
    input  logic                                               clock,

    // write port
    input  logic                                               write_en,
    input  icache_pkg::icache_index_t                          write_index,
    input  icache_pkg::mem_block_t                             write_data,

    // read ports, one per lane
    input  icache_pkg::icache_index_t [PREFETCH_DISTANCE-1:0]  read_index,
    output icache_pkg::mem_block_t    [PREFETCH_DISTANCE-1:0]  read_data
);
    import icache_pkg::*;

    // block array
    mem_block_t mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // write
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_index] <= write_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read
    //////////////////////////////////////////////////////////////////////
    // no bypass, same-cycle read of a written line sees old block
    always_comb begin
        for (int p = 0; p < PREFETCH_DISTANCE; p++) begin
            read_data[p] = mem[read_index[p]];
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_lane.sv
// one position of the lookup window
// offsets the base line by LANE, reads its tag entry and block,
// and reports hit, allocation flag and line address to the bundle

`timescale 1ns/1ps
`default_nettype none

module icache_lane #(
    parameter int LANE = 0
) (
    input  icache_pkg::line_addr_t                                 base_line,

    // tag state feeder
    input  icache_pkg::icache_tag_t [icache_pkg::ICACHE_LINES-1:0] tag_array,
    input  logic [icache_pkg::ICACHE_LINES-1:0]                    valid_array,
    input  logic [icache_pkg::ICACHE_LINES-1:0]                    alloc_array,

    // data store port
    output icache_pkg::icache_index_t                              read_index,
    input  icache_pkg::mem_block_t                                 read_data,

    // drain to the bundle
    output icache_pkg::mem_block_t                                 lane_data,
    output logic                                                   lane_hit,
    output logic                                                   lane_alloc,
    output icache_pkg::line_addr_t                                 lane_line
);
    import icache_pkg::*;

    fetch_addr_u   line_dec;
    icache_tag_t   line_tag;
    icache_index_t line_index;

    // successor line, wraps at 13 bits
    // carry out of the index bumps the tag
    assign lane_line = base_line + line_addr_t'(LANE);

    // rebuild a line-aligned address and split it
    assign line_dec.raw = addr_t'({lane_line, 3'b000});
    assign line_tag     = line_dec.fields.tag;
    assign line_index   = line_dec.fields.index;

    assign read_index = line_index;

    // hit needs valid entry and matching tag
    assign lane_hit   = valid_array[line_index] && (tag_array[line_index] == line_tag);
    assign lane_alloc = alloc_array[line_index];

    // block only shown on a hit, zero otherwise
    assign lane_data = lane_hit ? read_data : '0;

endmodule

`default_nettype wire

//--- logic/fetch_bundle.sv
// drains the lookup lanes into the fetch bundle
// counts the leading run of hits and picks the first line that
// is neither present nor already requested as the fill request

`timescale 1ns/1ps
`default_nettype none

module fetch_bundle #(
    parameter int PREFETCH_DISTANCE = 4
) (
    // lane results
    input  icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0] lane_data,
    input  logic [PREFETCH_DISTANCE-1:0]                   lane_hit,
    input  logic [PREFETCH_DISTANCE-1:0]                   lane_alloc,
    input  icache_pkg::line_addr_t [PREFETCH_DISTANCE-1:0] lane_line,

    // per-lane outputs
    output icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0] data_out,
    output logic [PREFETCH_DISTANCE-1:0]                   valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                   alloc_out,

    // leading hits, 0 to PREFETCH_DISTANCE
    output logic [3:0]                                     hit_run,

    // next line to request
    output logic                                           fill_req,
    output icache_pkg::addr_t                              fill_addr
);
    import icache_pkg::*;

    logic       run_open;
    logic       fill_found;
    line_addr_t fill_line;

    // pack lane results
    assign data_out  = lane_data;
    assign valid_out = lane_hit;
    assign alloc_out = lane_alloc;

    //////////////////////////////////////////////////////////////////////
    // leading hit count
    //////////////////////////////////////////////////////////////////////
    // run stops at the first miss from lane 0
    always_comb begin
        hit_run  = '0;
        run_open = 1'b1;
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            if (run_open && lane_hit[i]) begin
                hit_run = hit_run + 4'd1;
            end else begin
                run_open = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fill request
    //////////////////////////////////////////////////////////////////////
    // lowest lane that misses and has no request pending
    always_comb begin
        fill_found = 1'b0;
        fill_line  = '0;
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            if (!fill_found && !lane_hit[i] && !lane_alloc[i]) begin
                fill_found = 1'b1;
                fill_line  = lane_line[i];
            end
        end
    end

    assign fill_req = fill_found;

    // line aligned, offset zero
    assign fill_addr = fill_found ? addr_t'({fill_line, 3'b000}) : '0;

endmodule

`default_nettype wire

//--- logic/icache.sv
// instruction-cache lookup for the fetch stage
// looks up PREFETCH_DISTANCE consecutive lines from read_addr in one cycle
// fills, allocates and squashes are same-cycle strobes, seen next cycle

`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int PREFETCH_DISTANCE = 4
) (
    input  logic                                           clock,
    input  logic                                           reset,

    // lookup
    input  icache_pkg::addr_t                              read_addr,

    // fill
    input  logic                                           write_en,
    input  icache_pkg::addr_t                              write_addr,
    input  icache_pkg::mem_block_t                         write_data,

    // allocate
    input  logic                                           alloc_en,
    input  icache_pkg::addr_t                              alloc_addr,

    // branch logic
    input  icache_pkg::br_task_t                           br_task,

    // per-lane results
    output icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0] data_out,
    output logic [PREFETCH_DISTANCE-1:0]                   valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                   alloc_out,
    output logic [3:0]                                     hit_run,

    // fill request
    output logic                                           fill_req,
    output icache_pkg::addr_t                              fill_addr
);
    import icache_pkg::*;

    // address decode
    fetch_addr_u   read_dec;
    fetch_addr_u   write_dec;
    line_addr_t    base_line;
    icache_index_t write_index;
    logic          fill_write;

    // tag state feeder
    icache_tag_t [ICACHE_LINES-1:0] tag_array;
    logic [ICACHE_LINES-1:0]        valid_array;
    logic [ICACHE_LINES-1:0]        alloc_array;

    // data store ports
    icache_index_t [PREFETCH_DISTANCE-1:0] read_index;
    mem_block_t    [PREFETCH_DISTANCE-1:0] read_data;

    // lane drain
    mem_block_t [PREFETCH_DISTANCE-1:0] lane_data;
    logic       [PREFETCH_DISTANCE-1:0] lane_hit;
    logic       [PREFETCH_DISTANCE-1:0] lane_alloc;
    line_addr_t [PREFETCH_DISTANCE-1:0] lane_line;

    assign read_dec.raw  = read_addr;
    assign base_line     = {read_dec.fields.tag, read_dec.fields.index};
    assign write_dec.raw = write_addr;
    assign write_index   = write_dec.fields.index;

    // squash also discards the block write
    assign fill_write = write_en && (br_task != BR_SQUASH);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////
    icache_tag_store tag_store0 (
        .clock       (clock),
        .reset       (reset),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .alloc_en    (alloc_en),
        .alloc_addr  (alloc_addr),
        .br_task     (br_task),
        .tag_array   (tag_array),
        .valid_array (valid_array),
        .alloc_array (alloc_array)
    );

    icache_data_store #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .DEPTH             (ICACHE_LINES)
    ) data_store0 (
        .clock       (clock),
        .write_en    (fill_write),
        .write_index (write_index),
        .write_data  (write_data),
        .read_index  (read_index),
        .read_data   (read_data)
    );

    //////////////////////////////////////////////////////////////////////
    // lookup window
    //////////////////////////////////////////////////////////////////////
    for (genvar g = 0; g < PREFETCH_DISTANCE; g++) begin : lane_gen
        icache_lane #(
            .LANE (g)
        ) lane0 (
            .base_line   (base_line),
            .tag_array   (tag_array),
            .valid_array (valid_array),
            .alloc_array (alloc_array),
            .read_index  (read_index[g]),
            .read_data   (read_data[g]),
            .lane_data   (lane_data[g]),
            .lane_hit    (lane_hit[g]),
            .lane_alloc  (lane_alloc[g]),
            .lane_line   (lane_line[g])
        );
    end

    // collect lanes into the bundle
    fetch_bundle #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) bundle0 (
        .lane_data  (lane_data),
        .lane_hit   (lane_hit),
        .lane_alloc (lane_alloc),
        .lane_line  (lane_line),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .alloc_out  (alloc_out),
        .hit_run    (hit_run),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr)
    );

endmodule

`default_nettype wire

//--- test/icache_tb.sv
// self-checking testbench for the instruction-cache lookup block
// a table of steps drives fills, allocates and squashes, a behavioural
// model of tags, valid bits, allocation flags and blocks predicts every
// lookup output, and the table's own expected values are checked too

`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int PD              = 4;
    localparam int CLOCK_PERIOD_NS = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_STEPS       = 27;
    // table length plus reset plus some slack
    localparam int WATCHDOG_NS     = (NUM_STEPS + RESET_CYCLES + 20) * CLOCK_PERIOD_NS;

    // step operations
    localparam logic [2:0] OP_NONE        = 3'd0;
    localparam logic [2:0] OP_WRITE       = 3'd1;
    localparam logic [2:0] OP_ALLOC       = 3'd2;
    localparam logic [2:0] OP_SQUASH      = 3'd3;
    localparam logic [2:0] OP_WRITE_ALLOC = 3'd4;
    // squash with a write and an allocate in the same cycle
    localparam logic [2:0] OP_SQUASH_ALL  = 3'd5;

    // one table row, expected values are for the cycle the op is issued
    typedef struct packed {
        logic [2:0]    op;
        addr_t         waddr;
        addr_t         aaddr;
        addr_t         raddr;
        logic [PD-1:0] valid;
        logic [3:0]    run;
        logic          fill;
    } step_t;

    // DUT inputs
    logic       clock;
    logic       reset;
    addr_t      read_addr;
    logic       write_en;
    addr_t      write_addr;
    mem_block_t write_data;
    logic       alloc_en;
    addr_t      alloc_addr;
    br_task_t   br_task;

    // DUT outputs
    mem_block_t [PD-1:0] data_out;
    logic [PD-1:0]       valid_out;
    logic [PD-1:0]       alloc_out;
    logic [3:0]          hit_run;
    logic                fill_req;
    addr_t               fill_addr;

    // cache model
    icache_tag_t model_tag   [ICACHE_LINES];
    logic        model_valid [ICACHE_LINES];
    logic        model_alloc [ICACHE_LINES];
    mem_block_t  model_block [ICACHE_LINES];

    // predicted lookup
    mem_block_t [PD-1:0] exp_data;
    logic [PD-1:0]       exp_valid;
    logic [PD-1:0]       exp_alloc;
    logic [3:0]          exp_run;
    logic                exp_fill;
    addr_t               exp_fill_addr;

    step_t      steps [NUM_STEPS];
    integer     seed         = 32'hc51e;
    int         error_count  = 0;
    int         current_step = 0;
    mem_block_t step_data;

    icache #(
        .PREFETCH_DISTANCE (PD)
    ) dut0 (
        .clock      (clock),
        .reset      (reset),
        .read_addr  (read_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .br_task    (br_task),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .alloc_out  (alloc_out),
        .hit_run    (hit_run),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD_NS / 2) clock = ~clock;
    end

    // run limit
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the step table did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_block(input string name, input mem_block_t got, input mem_block_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t step %0d %s: got %h expected %h",
                     $time, current_step, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_lanes(input string name, input logic [PD-1:0] got,
                               input logic [PD-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t step %0d %s: got %b expected %b",
                     $time, current_step, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_run(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t step %0d %s: got %0d expected %0d",
                     $time, current_step, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED t=%0t step %0d %s: got %b expected %b",
                     $time, current_step, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t step %0d %s: got %h expected %h",
                     $time, current_step, name, got, exp);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // behavioural model
    //////////////////////////////////////////////////////////////////////
    task automatic clear_model();
        for (int i = 0; i < ICACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_alloc[i] = 1'b0;
            model_tag[i]   = '0;
            model_block[i] = '0;
        end
    endtask

    // window of consecutive lines, tag = addr[15:8], index = addr[7:3]
    task automatic predict_lookup(input addr_t raddr);
        logic [12:0] line;
        logic [4:0]  idx;
        logic        hit;
        logic        open_run;
        exp_run       = '0;
        exp_fill      = 1'b0;
        exp_fill_addr = '0;
        open_run      = 1'b1;
        for (int l = 0; l < PD; l++) begin
            line = raddr[15:3] + 13'(l);
            idx  = line[4:0];
            hit  = model_valid[idx] && (model_tag[idx] == line[12:5]);
            exp_valid[l] = hit;
            exp_alloc[l] = model_alloc[idx];
            // miss lanes show a zero block
            exp_data[l]  = hit ? model_block[idx] : '0;
            if (open_run && hit) begin
                exp_run = exp_run + 4'd1;
            end else begin
                open_run = 1'b0;
            end
            if (!exp_fill && !hit && !model_alloc[idx]) begin
                exp_fill      = 1'b1;
                exp_fill_addr = {16'h0000, line, 3'b000};
            end
        end
    endtask

    // squash wins, else write first and allocate after it
    task automatic apply_update(input step_t s, input mem_block_t data);
        logic [4:0] idx;
        if (s.op == OP_SQUASH || s.op == OP_SQUASH_ALL) begin
            for (int i = 0; i < ICACHE_LINES; i++) begin
                model_alloc[i] = 1'b0;
            end
        end else begin
            if (s.op == OP_WRITE || s.op == OP_WRITE_ALLOC) begin
                idx              = s.waddr[7:3];
                model_valid[idx] = 1'b1;
                model_alloc[idx] = 1'b0;
                model_tag[idx]   = s.waddr[15:8];
                model_block[idx] = data;
            end
            if (s.op == OP_ALLOC || s.op == OP_WRITE_ALLOC) begin
                model_alloc[s.aaddr[7:3]] = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic set_step(input int idx, input logic [2:0] op, input addr_t waddr,
                            input addr_t aaddr, input addr_t raddr, input logic [PD-1:0] valid,
                            input logic [3:0] run, input logic fill);
        steps[idx] = '{op, waddr, aaddr, raddr, valid, run, fill};
    endtask

    task automatic build_table();
        // after reset, unaligned read
        set_step(0, OP_NONE, 32'h0, 32'h0, 32'h0000_1204, 4'b0000, 4'd0, 1'b1);
        // fill four consecutive lines
        set_step(1, OP_WRITE, 32'h0000_1200, 32'h0, 32'h0000_1200, 4'b0000, 4'd0, 1'b1);
        set_step(2, OP_WRITE, 32'h0000_1208, 32'h0, 32'h0000_1200, 4'b0001, 4'd1, 1'b1);
        set_step(3, OP_WRITE, 32'h0000_1210, 32'h0, 32'h0000_1200, 4'b0011, 4'd2, 1'b1);
        set_step(4, OP_WRITE, 32'h0000_1218, 32'h0, 32'h0000_1200, 4'b0111, 4'd3, 1'b1);
        set_step(5, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1111, 4'd4, 1'b0);
        set_step(6, OP_NONE, 32'h0, 32'h0, 32'h0000_1208, 4'b0111, 4'd3, 1'b1);
        // window wrapping from index 31 to 0, tag 0x12 to 0x13
        set_step(7, OP_WRITE, 32'h0000_12f0, 32'h0, 32'h0000_12f0, 4'b0000, 4'd0, 1'b1);
        set_step(8, OP_WRITE, 32'h0000_12f8, 32'h0, 32'h0000_12f0, 4'b0001, 4'd1, 1'b1);
        set_step(9, OP_WRITE, 32'h0000_1300, 32'h0, 32'h0000_12f0, 4'b0011, 4'd2, 1'b1);
        set_step(10, OP_WRITE, 32'h0000_1308, 32'h0, 32'h0000_12f0, 4'b0111, 4'd3, 1'b1);
        set_step(11, OP_NONE, 32'h0, 32'h0, 32'h0000_12f0, 4'b1111, 4'd4, 1'b0);
        // lines 0 and 1 replaced, old tag misses
        set_step(12, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1100, 4'd0, 1'b1);
        // allocates move the fill request along
        set_step(13, OP_ALLOC, 32'h0, 32'h0000_1200, 32'h0000_1200, 4'b1100, 4'd0, 1'b1);
        set_step(14, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1100, 4'd0, 1'b1);
        set_step(15, OP_ALLOC, 32'h0, 32'h0000_1208, 32'h0000_1200, 4'b1100, 4'd0, 1'b1);
        set_step(16, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1100, 4'd0, 1'b0);
        // fill clears the allocation flag
        set_step(17, OP_WRITE, 32'h0000_1200, 32'h0, 32'h0000_1200, 4'b1100, 4'd0, 1'b0);
        set_step(18, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1101, 4'd1, 1'b0);
        // squash drops flags and that cycle's write and allocate
        set_step(19, OP_SQUASH_ALL, 32'h0000_1310, 32'h0000_1220, 32'h0000_1200,
                 4'b1101, 4'd1, 1'b0);
        set_step(20, OP_NONE, 32'h0, 32'h0, 32'h0000_1200, 4'b1101, 4'd1, 1'b1);
        set_step(21, OP_NONE, 32'h0, 32'h0, 32'h0000_1208, 4'b0110, 4'd0, 1'b1);
        // write and allocate on one line together
        set_step(22, OP_WRITE_ALLOC, 32'h0000_1208, 32'h0000_1208, 32'h0000_1208,
                 4'b0110, 4'd0, 1'b1);
        set_step(23, OP_NONE, 32'h0, 32'h0, 32'h0000_1208, 4'b0111, 4'd3, 1'b1);
        set_step(24, OP_SQUASH, 32'h0, 32'h0, 32'h0000_1208, 4'b0111, 4'd3, 1'b1);
        set_step(25, OP_NONE, 32'h0, 32'h0, 32'h0000_1208, 4'b0111, 4'd3, 1'b1);
        // upper address bits play no part
        set_step(26, OP_NONE, 32'h0, 32'h0, 32'habcd_1200, 4'b1111, 4'd4, 1'b0);
    endtask

    task automatic drive_step(input step_t s);
        logic squash;
        squash     = (s.op == OP_SQUASH || s.op == OP_SQUASH_ALL);
        read_addr  <= s.raddr;
        write_en   <= (s.op == OP_WRITE || s.op == OP_WRITE_ALLOC || s.op == OP_SQUASH_ALL);
        write_addr <= s.waddr;
        write_data <= step_data;
        alloc_en   <= (s.op == OP_ALLOC || s.op == OP_WRITE_ALLOC || s.op == OP_SQUASH_ALL);
        alloc_addr <= s.aaddr;
        // predict is a no-op for the cache
        if (squash) begin
            br_task <= BR_SQUASH;
        end else if (s.op == OP_NONE) begin
            br_task <= BR_PREDICT;
        end else begin
            br_task <= BR_NONE;
        end
    endtask

    task automatic check_outputs(input step_t s);
        for (int l = 0; l < PD; l++) begin
            check_block($sformatf("data_out[%0d]", l), data_out[l], exp_data[l]);
        end
        check_lanes("valid_out", valid_out, exp_valid);
        check_lanes("valid_out (table)", valid_out, s.valid);
        check_lanes("alloc_out", alloc_out, exp_alloc);
        check_run("hit_run", hit_run, exp_run);
        check_run("hit_run (table)", hit_run, s.run);
        check_flag("fill_req", fill_req, exp_fill);
        check_flag("fill_req (table)", fill_req, s.fill);
        check_addr("fill_addr", fill_addr, exp_fill_addr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        reset      = 1'b1;
        read_addr  = '0;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        alloc_en   = 1'b0;
        alloc_addr = '0;
        br_task    = BR_NONE;
        build_table();
        clear_model();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            @(posedge clock);
            current_step = i;
            step_data    = {$random(seed), $random(seed)};
            drive_step(steps[i]);
            // lookup settled mid-cycle, this step's op not yet taken
            @(negedge clock);
            predict_lookup(steps[i].raddr);
            check_outputs(steps[i]);
            apply_update(steps[i], step_data);
        end
        $display("%0d steps run, %0d errors", NUM_STEPS, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_lane.sv
logic/fetch_bundle.sv
logic/icache.sv
test/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction-cache testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := icache_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(SIM_BIN)
	@output="$$($(SIM_BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
